// ==== files.f ====
verilog/lsq_pkg.sv
verilog/lsq_head_ifs.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/addr_queue.sv
verilog/issue_select.sv
verilog/load_store_queue.sv
dv/lsq_sva.sv
dv/tb_load_store_queue.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_load_store_queue
FILELIST := files.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/tb_load_store_queue.sv ====
/*
 * Testbench for the load/store queue. Addresses are sent in request order
 * per kind, never ahead of their request. The scoreboard keeps one queue per
 * kind, since a load held back by a collision may be passed by stores.
 */
`timescale 1ns/1ns

module tb_load_store_queue
    import lsq_pkg::*;
();

    logic                clk = 1'b0;
    logic                rst;
    logic                push;
    logic                is_store;
    logic [OFFSET_W-1:0] offset;
    logic [2:0]          fn3;
    logic [3:0]          be;
    logic [31:0]         data;
    logic [ID_W-1:0]     id;
    logic                full;
    logic                addr_push;
    logic                addr_rnw;
    logic [PAGE_W-1:0]   addr_page;
    logic                addr_discard;
    logic                req_valid;
    logic                req_load;
    logic [31:0]         req_addr;
    logic [2:0]          req_fn3;
    logic [3:0]          req_be;
    logic [31:0]         req_data;
    logic [ID_W-1:0]     req_id;
    logic                req_ack;

    // Request as taken at the intake
    typedef struct packed {
        logic [OFFSET_W-1:0] offset;
        logic [2:0]          fn3;
        logic [3:0]          be;
        logic [31:0]         data;
        logic [ID_W-1:0]     id;
    } intake_t;

    // Request as it must show on the memory side
    typedef struct packed {
        logic [31:0]     addr;
        logic [2:0]      fn3;
        logic [3:0]      be;
        logic [31:0]     data;
        logic [ID_W-1:0] id;
    } expect_t;

    // Waiting for a page then waiting to transfer
    intake_t lq_pend [$];
    intake_t sq_pend [$];
    expect_t lq_exp  [$];
    expect_t sq_exp  [$];
    // Transfer kinds with 1 for a load
    bit      xfer_log [$];

    load_store_queue DUT (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Page above offset; loads take all lanes with no data, stores carry no fn3 or id
    function automatic expect_t expected_req(input logic load, input intake_t r,
                                             input logic [PAGE_W-1:0] page);
        expect_t e;
        e.addr = {page, r.offset};
        e.fn3  = load ? r.fn3 : 3'b000;
        e.be   = load ? 4'b1111 : r.be;
        e.data = load ? 32'd0 : r.data;
        e.id   = load ? r.id : '0;
        return e;
    endfunction

    // Word-address fold without the byte bits
    function automatic logic [4:0] fold_hash(input logic [OFFSET_W-1:0] off);
        return off[11:7] ^ off[6:2];
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, want);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard takes intake first so a bypassed page is known at its transfer
    always @(posedge clk) begin : scoreboard
        intake_t r;
        expect_t e;
        if (!rst) begin
            if (push && !full) begin
                r = {offset, fn3, be, data, id};
                if (is_store)
                    sq_pend.push_back(r);
                else
                    lq_pend.push_back(r);
            end
            if (addr_push) begin
                if ((addr_rnw ? lq_pend.size() : sq_pend.size()) == 0) begin
                    abort_run("page arrived with no request of its kind waiting");
                end else if (addr_rnw) begin
                    r = lq_pend.pop_front();
                    if (!addr_discard)
                        lq_exp.push_back(expected_req(1'b1, r, addr_page));
                end else begin
                    r = sq_pend.pop_front();
                    if (!addr_discard)
                        sq_exp.push_back(expected_req(1'b0, r, addr_page));
                end
            end
            if (req_valid && req_ack) begin
                if ((req_load ? lq_exp.size() : sq_exp.size()) == 0) begin
                    abort_run("transfer with no request of that kind expected");
                end else begin
                    e = req_load ? lq_exp.pop_front() : sq_exp.pop_front();
                    xfer_log.push_back(req_load);
                    compare(req_addr, e.addr, "req_addr");
                    compare(32'(req_fn3), 32'(e.fn3), "req_fn3");
                    compare(32'(req_be), 32'(e.be), "req_be");
                    compare(req_data, e.data, "req_data");
                    compare(32'(req_id), 32'(e.id), "req_id");
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic pick_payload();
        fn3  = 3'($urandom);
        be   = 4'($urandom);
        data = $urandom;
        id   = 4'($urandom);
    endtask

    // One accepted request after waiting out full
    task automatic drive_req(input logic st, input logic [OFFSET_W-1:0] off);
        int cycles;
        cycles = 0;
        while (full) begin
            if (cycles == 100) begin
                abort_run("queue stayed full, request could not be pushed");
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
        push     = 1'b1;
        is_store = st;
        offset   = off;
        pick_payload();
        @(posedge clk);
        #1;
        push = 1'b0;
    endtask

    task automatic drive_addr(input logic rnw, input logic [PAGE_W-1:0] page,
                              input logic disc);
        addr_push    = 1'b1;
        addr_rnw     = rnw;
        addr_page    = page;
        addr_discard = disc;
        @(posedge clk);
        #1;
        addr_push = 1'b0;
    endtask

    // Everything paired and transferred
    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (lq_exp.size() != 0 || sq_exp.size() != 0 ||
               lq_pend.size() != 0 || sq_pend.size() != 0) begin
            if (cycles == limit) begin
                abort_run("queued requests did not drain before the timeout");
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        int                  sent;
        int                  guard;
        logic [OFFSET_W-1:0] off;
        logic [OFFSET_W-1:0] off_ld;
        void'($urandom(18));
        rst          = 1'b1;
        push         = 1'b0;
        is_store     = 1'b0;
        offset       = '0;
        fn3          = '0;
        be           = '0;
        data         = '0;
        id           = '0;
        addr_push    = 1'b0;
        addr_rnw     = 1'b0;
        addr_page    = '0;
        addr_discard = 1'b0;
        req_ack      = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Single load then single store
        req_ack = 1'b1;
        drive_req(1'b0, 12'($urandom));
        drive_addr(1'b1, 20'($urandom), 1'b0);
        drive_req(1'b1, 12'($urandom));
        drive_addr(1'b0, 20'($urandom), 1'b0);
        wait_drain(50);
        compare(32'(req_valid), 32'd0, "req_valid after single load and store");

        // Load must win with both ready under back-pressure
        req_ack = 1'b0;
        xfer_log.delete();
        off    = 12'($urandom);
        off_ld = 12'($urandom);
        while (fold_hash(off_ld) == fold_hash(off))
            off_ld = 12'($urandom);
        drive_req(1'b1, off);
        drive_req(1'b0, off_ld);
        drive_addr(1'b0, 20'($urandom), 1'b0);
        drive_addr(1'b1, 20'($urandom), 1'b0);
        compare(32'(req_valid && req_load), 32'd1, "load presented over ready store");
        req_ack = 1'b1;
        wait_drain(50);
        compare(32'(xfer_log[0]), 32'd1, "load transfers first");
        compare(32'(xfer_log[1]), 32'd0, "store transfers second");

        // Load at the same offset waits for the older store
        req_ack = 1'b0;
        xfer_log.delete();
        off = 12'($urandom);
        drive_req(1'b1, off);
        drive_req(1'b0, off);
        drive_addr(1'b0, 20'($urandom), 1'b0);
        drive_addr(1'b1, 20'($urandom), 1'b0);
        compare(32'(req_valid && !req_load), 32'd1, "store presented while load blocked");
        req_ack = 1'b1;
        wait_drain(50);
        compare(32'(xfer_log[0]), 32'd0, "older store first");
        compare(32'(xfer_log[1]), 32'd1, "aliasing load after store");

        // Discarded loads and stores vanish while neighbours still go in order
        xfer_log.delete();
        repeat (3) drive_req(1'b0, 12'($urandom));
        repeat (2) drive_req(1'b1, 12'($urandom));
        drive_addr(1'b1, 20'($urandom), 1'b0);
        drive_addr(1'b1, 20'($urandom), 1'b1);
        drive_addr(1'b0, 20'($urandom), 1'b1);
        drive_addr(1'b1, 20'($urandom), 1'b0);
        drive_addr(1'b0, 20'($urandom), 1'b0);
        wait_drain(50);
        compare(32'(req_valid), 32'd0, "req_valid after discards");

        // Fill the store queue then push once more into full
        req_ack = 1'b0;
        xfer_log.delete();
        repeat (SQ_DEPTH) drive_req(1'b1, 12'($urandom));
        compare(32'(full), 32'd1, "full after SQ_DEPTH stores");
        push     = 1'b1;
        is_store = 1'b1;
        @(posedge clk);
        #1;
        push = 1'b0;
        compare(32'(full), 32'd1, "full after refused store");
        repeat (SQ_DEPTH) drive_addr(1'b0, 20'($urandom), 1'b0);
        req_ack = 1'b1;
        wait_drain(100);
        compare(32'(full), 32'd0, "full after stores drained");

        // Random mix over a small offset pool so collisions are common
        sent  = 0;
        guard = 0;
        while (sent < 40 || lq_pend.size() != 0 || sq_pend.size() != 0) begin
            if (guard == 2000) begin
                abort_run("random traffic did not finish before the timeout");
            end else begin
                push      = 1'b0;
                addr_push = 1'b0;
                if (sent < 40 && !full && $urandom_range(0, 2) != 0) begin
                    push     = 1'b1;
                    is_store = 1'($urandom_range(0, 1));
                    offset   = 12'($urandom_range(0, 15)) << 2;
                    pick_payload();
                    sent++;
                end
                if ((lq_pend.size() != 0 || sq_pend.size() != 0) &&
                    $urandom_range(0, 1) == 1) begin
                    addr_push    = 1'b1;
                    addr_rnw     = (sq_pend.size() == 0) ? 1'b1 :
                                   (lq_pend.size() == 0) ? 1'b0 : 1'($urandom_range(0, 1));
                    addr_page    = 20'($urandom);
                    addr_discard = ($urandom_range(0, 7) == 0);
                end
                req_ack = ($urandom_range(0, 3) != 0);
                @(posedge clk);
                #1;
                guard++;
            end
        end
        push      = 1'b0;
        addr_push = 1'b0;
        req_ack   = 1'b1;
        wait_drain(500);

        // Settled and empty
        repeat (4) @(posedge clk);
        #1;
        compare(32'(req_valid), 32'd0, "req_valid after drain");
        compare(32'(full), 32'd0, "full after drain");
        if (DUT.u_sva.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("ERROR: bound assertions failed during the run");
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule

// ==== dv/lsq_sva.sv ====
/*
 * Bound checks on reset and request behavior of the load/store queue.
 * Looks only at top-level ports plus the store write pointer.
 */
`timescale 1ns/1ns

module lsq_sva
    import lsq_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                push,
    input logic                is_store,
    input logic                full,
    input logic [SQ_PTR_W-1:0] sq_wr_ptr,
    input logic                req_valid,
    input logic                req_load
);

    // Failure count read by the testbench at the end
    int unsigned fail_count = 0;

    // Queues come out of reset empty
    reset_idle: assert property (@(posedge clk) rst |=> !req_valid)
        else begin
            $error("req_valid high in the cycle after reset");
            fail_count++;
        end

    kind_known: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !$isunknown(req_load))
        else begin
            $error("req_load unknown while req_valid is high");
            fail_count++;
        end

    // Refused store leaves the store queue untouched
    full_holds_sq: assert property (@(posedge clk) disable iff (rst)
        (push && is_store && full) |=> $stable(sq_wr_ptr))
        else begin
            $error("store queue moved on a refused push");
            fail_count++;
        end

endmodule

bind load_store_queue lsq_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .is_store  (is_store),
    .full      (full),
    .sq_wr_ptr (sq_wr_ptr),
    .req_valid (req_valid),
    .req_load  (req_load)
);

// ==== verilog/load_store_queue.sv ====
/*
 * Load/store queue top level. Requests must get their page address later
 * on the address channel, in request order per kind. One request is
 * offered at a time; full covers both kinds, even if only one queue is full.
 */
`timescale 1ns/1ns

module load_store_queue
    import lsq_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Request intake
    input  logic                push,
    input  logic                is_store,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [2:0]          fn3,
    input  logic [3:0]          be,
    input  logic [31:0]         data,
    input  logic [ID_W-1:0]     id,
    output logic                full,
    // Physical page channel
    input  logic                addr_push,
    input  logic                addr_rnw,
    input  logic [PAGE_W-1:0]   addr_page,
    input  logic                addr_discard,
    // Memory request
    output logic                req_valid,
    output logic                req_load,
    output logic [31:0]         req_addr,
    output logic [2:0]          req_fn3,
    output logic [3:0]          req_be,
    output logic [31:0]         req_data,
    output logic [ID_W-1:0]     req_id,
    input  logic                req_ack
);

    logic                push_ok;
    logic                sq_conflict;
    logic [SQ_PTR_W-1:0] sq_wr_ptr;
    logic                sq_full;
    logic                lq_full;

    lq_head_if   lq_head ();
    sq_head_if   sq_head ();
    addr_head_if lq_addr_head ();
    addr_head_if sq_addr_head ();

    assign full    = sq_full | lq_full;
    assign push_ok = push & ~full;

    ////////////////////////////////////////////////////////////////////////////
    // Intake queues
    store_queue u_store_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (push_ok),
        .is_store (is_store),
        .offset   (offset),
        .be       (be),
        .data     (data),
        .conflict (sq_conflict),
        .wr_ptr   (sq_wr_ptr),
        .full     (sq_full),
        .head     (sq_head)
    );

    load_queue u_load_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (push_ok),
        .is_store (is_store),
        .offset   (offset),
        .fn3      (fn3),
        .id       (id),
        .conflict (sq_conflict),
        .wr_ptr   (sq_wr_ptr),
        .full     (lq_full),
        .head     (lq_head)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Address pairing, rnw high for loads
    addr_queue #(.DEPTH(LQ_DEPTH)) u_lq_addr (
        .clk          (clk),
        .rst          (rst),
        .addr_push    (addr_push),
        .want_rnw     (1'b1),
        .addr_rnw     (addr_rnw),
        .addr_page    (addr_page),
        .addr_discard (addr_discard),
        .head         (lq_addr_head)
    );

    addr_queue #(.DEPTH(SQ_DEPTH)) u_sq_addr (
        .clk          (clk),
        .rst          (rst),
        .addr_push    (addr_push),
        .want_rnw     (1'b0),
        .addr_rnw     (addr_rnw),
        .addr_page    (addr_page),
        .addr_discard (addr_discard),
        .head         (sq_addr_head)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Issue select
    issue_select u_issue_select (
        .lq        (lq_head),
        .sq        (sq_head),
        .lq_addr   (lq_addr_head),
        .sq_addr   (sq_addr_head),
        .req_valid (req_valid),
        .req_load  (req_load),
        .req_addr  (req_addr),
        .req_fn3   (req_fn3),
        .req_be    (req_be),
        .req_data  (req_data),
        .req_id    (req_id),
        .req_ack   (req_ack)
    );

endmodule

// ==== verilog/issue_select.sv ====
/*
 * Pairs queue heads with their pages, drops discarded entries and picks
 * one request, loads first. Purely combinational. The presented request may
 * switch from a store to a load before it is acknowledged.
 */
`timescale 1ns/1ns

module issue_select
    import lsq_pkg::*;
(
    lq_head_if.sink             lq,
    sq_head_if.sink             sq,
    addr_head_if.sink           lq_addr,
    addr_head_if.sink           sq_addr,
    output logic                req_valid,
    output logic                req_load,
    output logic [31:0]         req_addr,
    output logic [2:0]          req_fn3,
    output logic [3:0]          req_be,
    output logic [31:0]         req_data,
    output logic [ID_W-1:0]     req_id,
    input  logic                req_ack
);

    logic      load_paired;
    logic      load_blocked;
    logic      load_discard;
    logic      load_ready;
    logic      store_paired;
    logic      store_discard;
    logic      store_ready;
    req_addr_t addr;

    ////////////////////////////////////////////////////////////////////////////
    // Loads
    assign load_paired = lq.valid & lq_addr.valid;

    // Wait for the tagged store slot to become oldest
    // An empty store queue also frees the load, in case younger stores
    // already moved the read pointer past the tag
    assign load_blocked = lq.collision & sq.valid & (lq.sq_tag != sq.oldest);

    // Discarded loads leave at once, ordering does not matter for them
    assign load_discard = load_paired & lq_addr.discard;
    assign load_ready   = load_paired & ~lq_addr.discard & ~load_blocked;

    ////////////////////////////////////////////////////////////////////////////
    // Stores
    assign store_paired = sq.valid & sq_addr.valid;
    assign store_ready  = store_paired & ~sq_addr.discard;

    // Drop a store only in a cycle where no load goes
    assign store_discard = store_paired & sq_addr.discard & ~load_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Request select, load over store
    assign req_valid = load_ready | store_ready;
    assign req_load  = load_ready;

    assign addr.field.page   = load_ready ? lq_addr.page : sq_addr.page;
    assign addr.field.offset = load_ready ? lq.offset : sq.offset;
    assign req_addr          = addr.flat;

    // Load: all byte lanes, no data; store: fn3 and id unused, driven zero
    assign req_fn3  = load_ready ? lq.fn3 : 3'b000;
    assign req_be   = load_ready ? 4'b1111 : sq.be;
    assign req_data = load_ready ? 32'd0 : sq.data;
    assign req_id   = load_ready ? lq.id : '0;

    // Pops: accepted transfer or discard, request and page together
    assign lq.pop      = load_discard | (load_ready & req_ack);
    assign lq_addr.pop = load_discard | (load_ready & req_ack);
    assign sq.pop      = store_discard | (store_ready & ~load_ready & req_ack);
    assign sq_addr.pop = store_discard | (store_ready & ~load_ready & req_ack);

endmodule

// ==== verilog/addr_queue.sv ====
/*
 * Physical page queue for one request kind, chosen by want_rnw.
 * No overflow check: addresses never outnumber queued requests, so DEPTH
 * must match the request queue it pairs with.
 */
`timescale 1ns/1ns

module addr_queue
    import lsq_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              addr_push,
    input  logic              want_rnw,
    input  logic              addr_rnw,
    input  logic [PAGE_W-1:0] addr_page,
    input  logic              addr_discard,
    addr_head_if.source       head
);

    logic [$clog2(DEPTH):0]   wr_ptr;
    logic [$clog2(DEPTH):0]   rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_idx;
    logic [$clog2(DEPTH)-1:0] rd_idx;

    logic [PAGE_W-1:0] page_mem    [DEPTH];
    logic              discard_mem [DEPTH];

    logic accept;
    logic empty;
    logic store_en;

    assign wr_idx = wr_ptr[$clog2(DEPTH)-1:0];
    assign rd_idx = rd_ptr[$clog2(DEPTH)-1:0];
    assign empty  = (wr_ptr == rd_ptr);

    // Only addresses of our own kind
    assign accept = addr_push & (addr_rnw == want_rnw);

    // Bypassed address consumed in its own cycle never lands in storage
    assign store_en = accept & ~(empty & head.pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (store_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (head.pop & ~empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            page_mem[wr_idx]    <= addr_page;
            discard_mem[wr_idx] <= addr_discard;
        end
    end

    // Empty queue shows the incoming address directly
    assign head.valid   = ~empty | accept;
    assign head.page    = empty ? addr_page : page_mem[rd_idx];
    assign head.discard = empty ? addr_discard : discard_mem[rd_idx];

endmodule

// ==== verilog/load_queue.sv ====
/*
 * Circular load buffer. Each entry keeps the alias flag and the store
 * write pointer seen at its push. push must already be gated with full.
 */
`timescale 1ns/1ns

module load_queue
    import lsq_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                is_store,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [2:0]          fn3,
    input  logic [ID_W-1:0]     id,
    input  logic                conflict,
    input  logic [SQ_PTR_W-1:0] wr_ptr,
    output logic                full,
    lq_head_if.source           head
);

    // Wrap-bit pointers
    logic [$clog2(LQ_DEPTH):0]   lq_wr;
    logic [$clog2(LQ_DEPTH):0]   lq_rd;
    logic [$clog2(LQ_DEPTH)-1:0] wr_idx;
    logic [$clog2(LQ_DEPTH)-1:0] rd_idx;
    logic                        enq;

    logic [OFFSET_W-1:0] offset_mem    [LQ_DEPTH];
    logic [2:0]          fn3_mem       [LQ_DEPTH];
    logic [ID_W-1:0]     id_mem        [LQ_DEPTH];
    logic                collision_mem [LQ_DEPTH];
    logic [SQ_PTR_W-1:0] sq_tag_mem    [LQ_DEPTH];

    assign enq    = push & ~is_store;
    assign wr_idx = lq_wr[$clog2(LQ_DEPTH)-1:0];
    assign rd_idx = lq_rd[$clog2(LQ_DEPTH)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            lq_wr <= '0;
            lq_rd <= '0;
        end else begin
            if (enq)
                lq_wr <= lq_wr + 1'b1;
            if (head.pop)
                lq_rd <= lq_rd + 1'b1;
        end
    end

    // Store slot at push time; all older stores sit below it
    always_ff @(posedge clk) begin
        if (enq) begin
            offset_mem[wr_idx]    <= offset;
            fn3_mem[wr_idx]       <= fn3;
            id_mem[wr_idx]        <= id;
            collision_mem[wr_idx] <= conflict;
            sq_tag_mem[wr_idx]    <= wr_ptr;
        end
    end

    assign full = (lq_wr[$clog2(LQ_DEPTH)] != lq_rd[$clog2(LQ_DEPTH)]) && (wr_idx == rd_idx);

    // Head
    assign head.valid     = (lq_wr != lq_rd);
    assign head.offset    = offset_mem[rd_idx];
    assign head.fn3       = fn3_mem[rd_idx];
    assign head.id        = id_mem[rd_idx];
    assign head.collision = collision_mem[rd_idx];
    assign head.sq_tag    = sq_tag_mem[rd_idx];

endmodule

// ==== verilog/store_queue.sv ====
/*
 * Circular store buffer with per-entry alias hash.
 * push must already be gated with full; an overrun is not detected here.
 * Store data comes with the request, so an entry is complete at push.
 */
`timescale 1ns/1ns

module store_queue
    import lsq_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                is_store,
    input  logic [OFFSET_W-1:0] offset,
    input  logic [3:0]          be,
    input  logic [31:0]         data,
    output logic                conflict,
    output logic [SQ_PTR_W-1:0] wr_ptr,
    output logic                full,
    sq_head_if.source           head
);

    logic [SQ_PTR_W-1:0] rd_ptr;
    logic [SQ_PTR_W-2:0] wr_idx;
    logic [SQ_PTR_W-2:0] rd_idx;
    logic                enq;

    logic [OFFSET_W-1:0] offset_mem [SQ_DEPTH];
    logic [3:0]          be_mem     [SQ_DEPTH];
    logic [31:0]         data_mem   [SQ_DEPTH];
    logic [HASH_W-1:0]   hash_mem   [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] valid_q;

    logic [HASH_W-1:0]   push_hash;
    logic [SQ_DEPTH-1:0] hash_hit;

    assign enq    = push & is_store;
    assign wr_idx = wr_ptr[SQ_PTR_W-2:0];
    assign rd_idx = rd_ptr[SQ_PTR_W-2:0];

    ////////////////////////////////////////////////////////////////////////////
    // Alias check against every pending store
    assign push_hash = addr_hash(offset);

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            hash_hit[i] = valid_q[i] & (hash_mem[i] == push_hash);
        end
    end

    // Only meaningful to the load queue, which latches it on a load push
    assign conflict = |hash_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and entry valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            valid_q <= '0;
        end else begin
            if (enq) begin
                wr_ptr          <= wr_ptr + 1'b1;
                valid_q[wr_idx] <= 1'b1;
            end
            // Push and pop never hit the same slot: full blocks push
            if (head.pop) begin
                rd_ptr          <= rd_ptr + 1'b1;
                valid_q[rd_idx] <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (enq) begin
            offset_mem[wr_idx] <= offset;
            be_mem[wr_idx]     <= be;
            data_mem[wr_idx]   <= data;
            hash_mem[wr_idx]   <= push_hash;
        end
    end

    // Same index, different wrap bit
    assign full = (wr_ptr[SQ_PTR_W-1] != rd_ptr[SQ_PTR_W-1]) && (wr_idx == rd_idx);

    ////////////////////////////////////////////////////////////////////////////
    // Head
    assign head.valid  = valid_q[rd_idx];
    assign head.offset = offset_mem[rd_idx];
    assign head.be     = be_mem[rd_idx];
    assign head.data   = data_mem[rd_idx];
    assign head.oldest = rd_ptr;

endmodule

// ==== verilog/lsq_head_ifs.sv ====
/*
 * Queue head interfaces between the intake queues and issue select.
 * A head is valid while its entry exists; pop at an edge removes it.
 * pop is only raised while the head is valid.
 */
`timescale 1ns/1ns

// Load queue head
interface lq_head_if
    import lsq_pkg::*;
();
    logic                valid;
    logic [OFFSET_W-1:0] offset;
    logic [2:0]          fn3;
    logic [ID_W-1:0]     id;
    // Possible alias with an older store, and the store slot to wait for
    logic                collision;
    logic [SQ_PTR_W-1:0] sq_tag;
    logic                pop;

    modport source (output valid, offset, fn3, id, collision, sq_tag, input pop);
    modport sink (input valid, offset, fn3, id, collision, sq_tag, output pop);
endinterface

// Store queue head
interface sq_head_if
    import lsq_pkg::*;
();
    logic                valid;
    logic [OFFSET_W-1:0] offset;
    logic [3:0]          be;
    logic [31:0]         data;
    // Read pointer with wrap bit, compared against load sq_tag
    logic [SQ_PTR_W-1:0] oldest;
    logic                pop;

    modport source (output valid, offset, be, data, oldest, input pop);
    modport sink (input valid, offset, be, data, oldest, output pop);
endinterface

// Address queue head, one instance per request kind
interface addr_head_if
    import lsq_pkg::*;
();
    logic              valid;
    logic [PAGE_W-1:0] page;
    // Faulted or cancelled request
    logic              discard;
    logic              pop;

    modport source (output valid, page, discard, input pop);
    modport sink (input valid, page, discard, output pop);
endinterface

// ==== verilog/lsq_pkg.sv ====
/*
 * Shared sizes, alias hash and request address view for the load/store queue.
 * SQ_PTR_W must stay one bit wider than the store index, since the wrap bit
 * tells a full store queue apart from an empty one.
 */
package lsq_pkg;

    // Queue sizes
    localparam int LQ_DEPTH = 8;
    localparam int SQ_DEPTH = 4;
    localparam int SQ_PTR_W = 3;

    // Field widths
    localparam int OFFSET_W = 12;
    localparam int PAGE_W   = 20;
    localparam int ID_W     = 4;
    localparam int HASH_W   = 5;

    // Folded word-address hash, byte bits left out
    // Different words can share a hash, so a match only means a possible alias
    function automatic logic [HASH_W-1:0] addr_hash(input logic [OFFSET_W-1:0] offset);
        return offset[11:7] ^ offset[6:2];
    endfunction

    // One request address, seen flat or as page above offset
    typedef union packed {
        logic [PAGE_W+OFFSET_W-1:0] flat;
        struct packed {
            logic [PAGE_W-1:0]   page;
            logic [OFFSET_W-1:0] offset;
        } field;
    } req_addr_t;

endpackage
